// ==== src/cmtx_fmt_pkg.sv ====
// numeric formats of the colour matrix datapath
// pixel, coefficient, offset and accumulator widths and types

package cmtx_fmt_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int PIXEL_WIDTH  = 8;
    localparam int COEFF_WIDTH  = 16;
    localparam int OFFSET_WIDTH = 24;
    localparam int ACC_WIDTH    = 40;

    // 1.0 == 1024
    localparam int FRAC_BITS    = 10;

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef logic        [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [COEFF_WIDTH-1:0]  coeff_t;

    // offset is in accumulator units
    typedef logic signed [OFFSET_WIDTH-1:0] offset_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;

endpackage

// ==== src/cmtx_reg_pkg.sv ====
// host register map of the colour matrix
// coefficient rows, apply address and reset values

package cmtx_reg_pkg;

    localparam int ADDR_WIDTH = 4;
    localparam int DATA_WIDTH = 32;

    // ----------------------------------------
    // address map
    // ----------------------------------------
    // row r holds a, b, c, d at r*4 .. r*4+3
    localparam logic [ADDR_WIDTH-1:0] COEFF_ROW_STRIDE = 4'd4;

    // any write here commits shadow to active
    localparam logic [ADDR_WIDTH-1:0] APPLY_ADDR = 4'd12;

    // ----------------------------------------
    // reset values
    // ----------------------------------------
    localparam cmtx_fmt_pkg::coeff_t IDENTITY_ONE = 16'sd1024;

endpackage

// ==== src/coeff_if.sv ====
// coefficient interface
// one row of the active matrix, a b c and offset d
`timescale 1ns/1ns

interface coeff_if;
    cmtx_fmt_pkg::coeff_t  a;
    cmtx_fmt_pkg::coeff_t  b;
    cmtx_fmt_pkg::coeff_t  c;
    cmtx_fmt_pkg::offset_t d;

    modport src (
        output a,
        output b,
        output c,
        output d
    );

    modport dst (
        input a,
        input b,
        input c,
        input d
    );
endinterface

// ==== src/cmtx_coeff_regs.sv ====
// coefficient registers, shadow bank and active bank
// host write decode and apply commit
`timescale 1ns/1ns

module cmtx_coeff_regs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_en,
    input  logic [cmtx_reg_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  logic [cmtx_reg_pkg::DATA_WIDTH-1:0] wr_data,
    coeff_if.src                                row0,
    coeff_if.src                                row1,
    coeff_if.src                                row2
);

    cmtx_fmt_pkg::coeff_t  shadow_abc [0:2][0:2];
    cmtx_fmt_pkg::offset_t shadow_d   [0:2];
    cmtx_fmt_pkg::coeff_t  active_abc [0:2][0:2];
    cmtx_fmt_pkg::offset_t active_d   [0:2];

    logic [1:0] row_sel;
    logic [1:0] col_sel;
    logic       coeff_wr;
    logic       apply_wr;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    assign row_sel  = 2'(wr_addr / cmtx_reg_pkg::COEFF_ROW_STRIDE);
    assign col_sel  = 2'(wr_addr % cmtx_reg_pkg::COEFF_ROW_STRIDE);
    assign coeff_wr = wr_en && (wr_addr < cmtx_reg_pkg::APPLY_ADDR);
    assign apply_wr = wr_en && (wr_addr == cmtx_reg_pkg::APPLY_ADDR);

    // shadow bank, host writes land here
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 3; r++) begin
                for (int k = 0; k < 3; k++) begin
                    shadow_abc[r][k] <= (r == k) ? cmtx_reg_pkg::IDENTITY_ONE : '0;
                end
                shadow_d[r] <= '0;
            end
        end else if (coeff_wr) begin
            // last slot of a row is the offset
            if (col_sel == 2'd3) begin
                shadow_d[row_sel] <= $signed(wr_data[cmtx_fmt_pkg::OFFSET_WIDTH-1:0]);
            end else begin
                shadow_abc[row_sel][col_sel] <=
                    $signed(wr_data[cmtx_fmt_pkg::COEFF_WIDTH-1:0]);
            end
        end
    end

    // active bank, whole matrix at once
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 3; r++) begin
                for (int k = 0; k < 3; k++) begin
                    active_abc[r][k] <= (r == k) ? cmtx_reg_pkg::IDENTITY_ONE : '0;
                end
                active_d[r] <= '0;
            end
        end else if (apply_wr) begin
            active_abc <= shadow_abc;
            active_d   <= shadow_d;
        end
    end

    // ----------------------------------------
    // row outputs
    // ----------------------------------------
    assign row0.a = active_abc[0][0];
    assign row0.b = active_abc[0][1];
    assign row0.c = active_abc[0][2];
    assign row0.d = active_d[0];
    assign row1.a = active_abc[1][0];
    assign row1.b = active_abc[1][1];
    assign row1.c = active_abc[1][2];
    assign row1.d = active_d[1];
    assign row2.a = active_abc[2][0];
    assign row2.b = active_abc[2][1];
    assign row2.c = active_abc[2][2];
    assign row2.d = active_d[2];

endmodule

// ==== src/cmtx_mul_add3.sv ====
// three-term multiply-add pipeline, a*x + b*y + c*z + d
// five stages, one clock enable for the whole datapath
`timescale 1ns/1ns

module cmtx_mul_add3 #(
    parameter int A_WIDTH      = 16,
    parameter int X_WIDTH      = 9,
    parameter int D_WIDTH      = 24,
    parameter int P_WIDTH      = 40,
    parameter int STATIC_COEFF = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cke,
    input  logic signed [A_WIDTH-1:0] a,
    input  logic signed [A_WIDTH-1:0] b,
    input  logic signed [A_WIDTH-1:0] c,
    input  logic signed [D_WIDTH-1:0] d,
    input  logic signed [X_WIDTH-1:0] x,
    input  logic signed [X_WIDTH-1:0] y,
    input  logic signed [X_WIDTH-1:0] z,
    output logic signed [P_WIDTH-1:0] p
);

    localparam int M_WIDTH = A_WIDTH + X_WIDTH;

    logic signed [A_WIDTH-1:0] st0_a, st0_b, st0_c;
    logic signed [D_WIDTH-1:0] st0_d;
    logic signed [X_WIDTH-1:0] st0_x, st0_y, st0_z;

    logic signed [A_WIDTH-1:0] st1_a, st1_b;
    logic signed [D_WIDTH-1:0] st1_d;
    logic signed [X_WIDTH-1:0] st1_x, st1_y;
    logic signed [M_WIDTH-1:0] st1_z;

    logic signed [A_WIDTH-1:0] st2_a;
    logic signed [X_WIDTH-1:0] st2_x;
    logic signed [M_WIDTH-1:0] st2_y;
    logic signed [P_WIDTH-1:0] st2_z;

    logic signed [M_WIDTH-1:0] st3_x;
    logic signed [P_WIDTH-1:0] st3_p;

    logic signed [P_WIDTH-1:0] st4_p;

    always_ff @(posedge clk) begin
        if (reset) begin
            {st0_a, st0_b, st0_c, st0_d, st0_x, st0_y, st0_z} <= '0;
            {st1_a, st1_b, st1_d, st1_x, st1_y, st1_z} <= '0;
            {st2_a, st2_x, st2_y, st2_z} <= '0;
            {st3_x, st3_p} <= '0;
            st4_p <= '0;
        end else if (cke) begin
            // stage 0, capture everything
            st0_a <= a;
            st0_b <= b;
            st0_c <= c;
            st0_d <= d;
            st0_x <= x;
            st0_y <= y;
            st0_z <= z;

            // stage 1, c*z
            // static coefficients are read live instead of from stage 0
            st1_a <= (STATIC_COEFF != 0) ? a : st0_a;
            st1_b <= st0_b;
            st1_d <= (STATIC_COEFF != 0) ? d : st0_d;
            st1_x <= st0_x;
            st1_y <= st0_y;
            st1_z <= M_WIDTH'(st0_c) * M_WIDTH'(st0_z);

            // stage 2, b*y and offset
            st2_a <= st1_a;
            st2_x <= st1_x;
            st2_y <= M_WIDTH'(st1_b) * M_WIDTH'(st1_y);
            st2_z <= P_WIDTH'(st1_d) + P_WIDTH'(st1_z);

            // stage 3, a*x and partial sum
            st3_x <= M_WIDTH'(st2_a) * M_WIDTH'(st2_x);
            st3_p <= st2_z + P_WIDTH'(st2_y);

            // stage 4
            st4_p <= st3_p + P_WIDTH'(st3_x);
        end
    end

    assign p = st4_p;

endmodule

// ==== src/cmtx_round_sat.sv ====
// round and saturate of the accumulator into an unsigned pixel
`timescale 1ns/1ns

module cmtx_round_sat #(
    parameter int ACC_WIDTH   = cmtx_fmt_pkg::ACC_WIDTH,
    parameter int FRAC_BITS   = cmtx_fmt_pkg::FRAC_BITS,
    parameter int PIXEL_WIDTH = cmtx_fmt_pkg::PIXEL_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cke,
    input  cmtx_fmt_pkg::acc_t   acc,
    output cmtx_fmt_pkg::pixel_t pix
);

    // half an lsb of the output
    localparam logic signed [ACC_WIDTH:0] HALF =
        {{(ACC_WIDTH - FRAC_BITS + 1){1'b0}}, 1'b1, {(FRAC_BITS - 1){1'b0}}};
    localparam logic signed [ACC_WIDTH:0] PIX_MAX =
        {{(ACC_WIDTH - PIXEL_WIDTH + 1){1'b0}}, {PIXEL_WIDTH{1'b1}}};

    logic signed [ACC_WIDTH:0] rounded;
    logic signed [ACC_WIDTH:0] shifted;

    // one guard bit so the add never wraps
    assign rounded = $signed({acc[ACC_WIDTH-1], acc}) + HALF;
    assign shifted = rounded >>> FRAC_BITS;

    always_ff @(posedge clk) begin
        if (reset) begin
            pix <= '0;
        end else if (cke) begin
            if (shifted[ACC_WIDTH]) begin
                pix <= '0;
            end else if (shifted > PIX_MAX) begin
                pix <= {PIXEL_WIDTH{1'b1}};
            end else begin
                pix <= shifted[PIXEL_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== src/cmtx_channel.sv ====
// one output channel of the colour matrix
// multiply-add pipeline, round/saturate and valid tracking
`timescale 1ns/1ns

module cmtx_channel #(
    parameter int FRAC_BITS    = cmtx_fmt_pkg::FRAC_BITS,
    parameter int STATIC_COEFF = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cke,
    input  logic                 in_valid,
    input  cmtx_fmt_pkg::pixel_t x,
    input  cmtx_fmt_pkg::pixel_t y,
    input  cmtx_fmt_pkg::pixel_t z,
    coeff_if.dst                 coeff,
    output logic                 out_valid,
    output cmtx_fmt_pkg::pixel_t pix
);

    // five multiply-add stages plus the round register
    localparam int LATENCY = 6;
    localparam int OP_WIDTH = cmtx_fmt_pkg::PIXEL_WIDTH + 1;

    logic signed [OP_WIDTH-1:0] xs, ys, zs;
    cmtx_fmt_pkg::acc_t         acc;
    logic [LATENCY-1:0]         vld_sr;

    // pixels are unsigned
    assign xs = $signed({1'b0, x});
    assign ys = $signed({1'b0, y});
    assign zs = $signed({1'b0, z});

    cmtx_mul_add3 #(
        .A_WIDTH      (cmtx_fmt_pkg::COEFF_WIDTH),
        .X_WIDTH      (OP_WIDTH),
        .D_WIDTH      (cmtx_fmt_pkg::OFFSET_WIDTH),
        .P_WIDTH      (cmtx_fmt_pkg::ACC_WIDTH),
        .STATIC_COEFF (STATIC_COEFF)
    ) mul_add_inst (
        .clk   (clk),
        .reset (reset),
        .cke   (cke),
        .a     (coeff.a),
        .b     (coeff.b),
        .c     (coeff.c),
        .d     (coeff.d),
        .x     (xs),
        .y     (ys),
        .z     (zs),
        .p     (acc)
    );

    cmtx_round_sat #(
        .ACC_WIDTH   (cmtx_fmt_pkg::ACC_WIDTH),
        .FRAC_BITS   (FRAC_BITS),
        .PIXEL_WIDTH (cmtx_fmt_pkg::PIXEL_WIDTH)
    ) round_sat_inst (
        .clk   (clk),
        .reset (reset),
        .cke   (cke),
        .acc   (acc),
        .pix   (pix)
    );

    // valid follows the data, frozen with it
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_sr <= '0;
        end else if (cke) begin
            vld_sr <= {vld_sr[LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = vld_sr[LATENCY-1];

endmodule

// ==== src/cmtx_top.sv ====
// colour matrix conversion top level
// coefficient registers and three output channels
`timescale 1ns/1ns

module cmtx_top #(
    parameter int FRAC_BITS    = cmtx_fmt_pkg::FRAC_BITS,
    parameter int STATIC_COEFF = 0
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_en,
    input  logic [cmtx_reg_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  logic [cmtx_reg_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic                                cke,
    input  logic                                in_valid,
    input  cmtx_fmt_pkg::pixel_t                in_r,
    input  cmtx_fmt_pkg::pixel_t                in_g,
    input  cmtx_fmt_pkg::pixel_t                in_b,
    output logic                                out_valid,
    output cmtx_fmt_pkg::pixel_t                out_c0,
    output cmtx_fmt_pkg::pixel_t                out_c1,
    output cmtx_fmt_pkg::pixel_t                out_c2
);

    coeff_if row0_if ();
    coeff_if row1_if ();
    coeff_if row2_if ();

    cmtx_coeff_regs coeff_regs_inst (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .row0    (row0_if.src),
        .row1    (row1_if.src),
        .row2    (row2_if.src)
    );

    // ----------------------------------------
    // channels, all share valid timing
    // ----------------------------------------
    cmtx_channel #(
        .FRAC_BITS    (FRAC_BITS),
        .STATIC_COEFF (STATIC_COEFF)
    ) channel0_inst (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .in_valid  (in_valid),
        .x         (in_r),
        .y         (in_g),
        .z         (in_b),
        .coeff     (row0_if.dst),
        .out_valid (out_valid),
        .pix       (out_c0)
    );

    cmtx_channel #(
        .FRAC_BITS    (FRAC_BITS),
        .STATIC_COEFF (STATIC_COEFF)
    ) channel1_inst (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .in_valid  (in_valid),
        .x         (in_r),
        .y         (in_g),
        .z         (in_b),
        .coeff     (row1_if.dst),
        .out_valid (),
        .pix       (out_c1)
    );

    cmtx_channel #(
        .FRAC_BITS    (FRAC_BITS),
        .STATIC_COEFF (STATIC_COEFF)
    ) channel2_inst (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .in_valid  (in_valid),
        .x         (in_r),
        .y         (in_g),
        .z         (in_b),
        .coeff     (row2_if.dst),
        .out_valid (),
        .pix       (out_c2)
    );

endmodule

// ==== tb/cmtx_clk_gen.sv ====
// testbench clock and power-on reset
`timescale 1ns/1ns

module cmtx_clk_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // held over the first rising edges, released on an edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== tb/cmtx_tb.sv ====
// colour matrix testbench
// directed tests, reference model, output checks and summary
`timescale 1ns/1ns

module cmtx_tb;

    localparam int LATENCY     = 6;
    localparam int DRAIN_LIMIT = 200;

    logic                 clk;
    logic                 reset;
    logic                 wr_en;
    logic [3:0]           wr_addr;
    logic [31:0]          wr_data;
    logic                 cke;
    logic                 in_valid;
    cmtx_fmt_pkg::pixel_t in_r, in_g, in_b;
    logic                 out_valid;
    cmtx_fmt_pkg::pixel_t out_c0, out_c1, out_c2;

    int          seed = 32'h01f5_3c74;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          err_mark;
    int          check_mark;
    int          edge_cnt = 0;
    // committed and shadow matrix, column 3 is the offset
    int          mdl [0:2][0:3];
    int          shd [0:2][0:3];
    logic [23:0] exp_q [$];
    int          acc_edge_q [$];

    cmtx_clk_gen clk_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    cmtx_top cmtx_top_inst (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .cke       (cke),
        .in_valid  (in_valid),
        .in_r      (in_r),
        .in_g      (in_g),
        .in_b      (in_b),
        .out_valid (out_valid),
        .out_c0    (out_c0),
        .out_c1    (out_c1),
        .out_c2    (out_c2)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [7:0] ref_pixel(input int row, input int x, input int y,
                                             input int z);
        longint s;
        s = longint'(mdl[row][0]) * longint'(x) + longint'(mdl[row][1]) * longint'(y)
            + longint'(mdl[row][2]) * longint'(z) + longint'(mdl[row][3]);
        s = (s + (longint'(1) << (cmtx_fmt_pkg::FRAC_BITS - 1))) >>> cmtx_fmt_pkg::FRAC_BITS;
        if (s < 0) begin
            return 8'h00;
        end
        if (s > 255) begin
            return 8'hff;
        end
        return 8'(s);
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        check_cnt++;
        assert (got == expected) else begin
            $display("FAILED %s got %h expected %h", name, got, expected);
            err_cnt++;
        end
    endtask

    // only enabled edges count, pre-edge values are sampled
    always @(posedge clk) begin : monitor
        logic [23:0] expected;
        int          lat;
        if (!reset && cke) begin
            edge_cnt++;
            if (out_valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("out_valid was high with no pixel in flight");
                    err_cnt++;
                end
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();
                    lat = edge_cnt - acc_edge_q.pop_front();
                    assert (lat == LATENCY) else begin
                        $display("output came %0d enabled cycles after its pixel", lat);
                        err_cnt++;
                    end
                    check_value("out_c0", out_c0, expected[23:16]);
                    check_value("out_c1", out_c1, expected[15:8]);
                    check_value("out_c2", out_c2, expected[7:0]);
                end
            end
            if (in_valid) begin
                exp_q.push_back({ref_pixel(0, int'(in_r), int'(in_g), int'(in_b)),
                                 ref_pixel(1, int'(in_r), int'(in_g), int'(in_b)),
                                 ref_pixel(2, int'(in_r), int'(in_g), int'(in_b))});
                acc_edge_q.push_back(edge_cnt);
            end
        end
    end

    // ----------------------------------------
    // drivers
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic host_write(input logic [3:0] addr, input logic [31:0] data);
        int row;
        int col;
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        next_cycle();
        wr_en = 1'b0;
        row = int'(addr) / int'(cmtx_reg_pkg::COEFF_ROW_STRIDE);
        col = int'(addr) % int'(cmtx_reg_pkg::COEFF_ROW_STRIDE);
        if (addr == cmtx_reg_pkg::APPLY_ADDR) begin
            mdl = shd;
        end else if (addr < cmtx_reg_pkg::APPLY_ADDR) begin
            if (col == 3) begin
                shd[row][col] = int'($signed(data[cmtx_fmt_pkg::OFFSET_WIDTH-1:0]));
            end else begin
                shd[row][col] = int'($signed(data[cmtx_fmt_pkg::COEFF_WIDTH-1:0]));
            end
        end
    endtask

    task automatic load_row(input int r, input int a, input int b, input int c, input int d);
        logic [3:0] base;
        base = 4'(r * int'(cmtx_reg_pkg::COEFF_ROW_STRIDE));
        host_write(base, a);
        host_write(base + 4'd1, b);
        host_write(base + 4'd2, c);
        host_write(base + 4'd3, d);
    endtask

    task automatic load_ycbcr();
        load_row(0, 263, 516, 100, 16 * 1024);
        load_row(1, -152, -298, 450, 128 * 1024);
        load_row(2, 450, -377, -73, 128 * 1024);
    endtask

    // channel order rotated, no offsets
    task automatic load_swap();
        load_row(0, 0, 0, 1024, 0);
        load_row(1, 1024, 0, 0, 0);
        load_row(2, 0, 1024, 0, 0);
    endtask

    task automatic set_random_pixel();
        in_r     = 8'($random(seed));
        in_g     = 8'($random(seed));
        in_b     = 8'($random(seed));
        in_valid = 1'b1;
    endtask

    task automatic stream_random(input int count, input bit stall);
        int gap;
        for (int i = 0; i < count; i++) begin
            set_random_pixel();
            if (stall) begin
                gap = int'($unsigned($random(seed)) % 32'd4);
                cke = 1'b0;
                repeat (gap) next_cycle();
                cke = 1'b1;
            end
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        in_valid = 1'b0;
        cke      = 1'b1;
        waited   = 0;
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timed out waiting for %0d outputs", exp_q.size());
            err_cnt++;
            exp_q.delete();
            acc_edge_q.delete();
        end
        // idle cycles catch any extra out_valid
        repeat (8) next_cycle();
    endtask

    task automatic mark_start();
        err_mark   = err_cnt;
        check_mark = check_cnt;
    endtask

    task automatic report_result(input string name);
        $display("%s: %0d checks, %0d errors", name, check_cnt - check_mark,
                 err_cnt - err_mark);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic reset_identity();
        mark_start();
        stream_random(16, 1'b0);
        drain_outputs();
        report_result("reset_identity");
    endtask

    task automatic programmed_matrix();
        mark_start();
        load_ycbcr();
        host_write(cmtx_reg_pkg::APPLY_ADDR, 32'd0);
        stream_random(32, 1'b0);
        drain_outputs();
        report_result("programmed_matrix");
    endtask

    task automatic shadow_isolation();
        mark_start();
        load_swap();
        stream_random(12, 1'b0);
        drain_outputs();
        host_write(cmtx_reg_pkg::APPLY_ADDR, 32'd0);
        stream_random(12, 1'b0);
        drain_outputs();
        report_result("shadow_isolation");
    endtask

    task automatic saturation_rounding();
        mark_start();
        load_row(0, -2048, 1024, 0, 0);
        load_row(1, 1024, 0, 0, 32'h0007_ffff);
        load_row(2, 512, 0, 0, 0);
        host_write(cmtx_reg_pkg::APPLY_ADDR, 32'd0);
        // odd red values put row 2 exactly on half steps
        for (int i = 0; i < 16; i++) begin
            set_random_pixel();
            in_r = 8'(34 * i + 1);
            next_cycle();
        end
        drain_outputs();
        report_result("saturation_rounding");
    endtask

    task automatic stall_stream();
        mark_start();
        load_ycbcr();
        host_write(cmtx_reg_pkg::APPLY_ADDR, 32'd0);
        stream_random(40, 1'b1);
        drain_outputs();
        report_result("stall_stream");
    endtask

    task automatic apply_midstream();
        mark_start();
        set_random_pixel();
        next_cycle();
        in_valid = 1'b0;
        load_swap();
        // this pixel shares the apply edge and keeps the old matrix
        set_random_pixel();
        host_write(cmtx_reg_pkg::APPLY_ADDR, 32'd0);
        stream_random(4, 1'b0);
        drain_outputs();
        report_result("apply_midstream");
    endtask

    initial begin
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        cke      = 1'b1;
        in_valid = 1'b0;
        in_r     = '0;
        in_g     = '0;
        in_b     = '0;
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 4; k++) begin
                mdl[r][k] = (r == k) ? 1024 : 0;
            end
        end
        shd = mdl;
        for (int i = 0; i < 20 && reset !== 1'b0; i++) begin
            next_cycle();
        end
        assert (reset === 1'b0) else begin
            $display("reset never went low");
            err_cnt++;
        end
        reset_identity();
        programmed_matrix();
        shadow_isolation();
        saturation_rounding();
        stall_stream();
        apply_midstream();
        $display("total: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("simulation ran past its time limit");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== flist.f ====
src/cmtx_fmt_pkg.sv
src/cmtx_reg_pkg.sv
src/coeff_if.sv
src/cmtx_coeff_regs.sv
src/cmtx_mul_add3.sv
src/cmtx_round_sat.sv
src/cmtx_channel.sv
src/cmtx_top.sv
tb/cmtx_clk_gen.sv
tb/cmtx_tb.sv

// ==== build.sh ====
#!/bin/sh
# build and run the colour matrix testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cmtx_tb -f flist.f

out=$(./obj_dir/Vcmtx_tb)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
